//--- hdl/bypass_defs.svh
// Operand forwarding sizes shared by the bypass package and RTL
`ifndef BYPASS_DEFS_SVH
`define BYPASS_DEFS_SVH

// Number of in-flight result stages between execute and retirement
`define BYPASS_DEPTH 3

// Operand read ports searching the bypass
`define READ_PORTS 2

// Integer data path width
`define WORD_WIDTH 32

// Register number width, 32 architectural registers
`define REG_ADDR_WIDTH 5

`endif

//--- hdl/BypassPkg.sv
// Bypass types for register numbers, data words and stage positions
package BypassPkg;

`include "bypass_defs.svh"

    // Register number, value 0 is the hard-wired zero register
    typedef logic [`REG_ADDR_WIDTH-1:0] RegAddr;

    // Operand or result value
    typedef logic [`WORD_WIDTH-1:0] Word;

    // Position in the bypass pipeline, stage 0 is the newest
    typedef logic [$clog2(`BYPASS_DEPTH)-1:0] StageIndex;

endpackage

//--- hdl/BypassPipeline.sv
// Bypass pipeline of in-flight results with stall hold, flush clear and retirement
`timescale 1ns/1ps

`include "bypass_defs.svh"

module BypassPipeline (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       stall,
    input  logic                       writeEnable,
    input  BypassPkg::RegAddr          writeAddr,
    input  BypassPkg::Word             writeValue,
    output logic [`BYPASS_DEPTH-1:0]   stageValid,
    output BypassPkg::RegAddr          stageAddr [`BYPASS_DEPTH],
    output BypassPkg::Word             stageValue [`BYPASS_DEPTH],
    output logic                       retireEnable,
    output BypassPkg::RegAddr          retireAddr,
    output BypassPkg::Word             retireValue
);
    import BypassPkg::*;

    localparam int LastStage = `BYPASS_DEPTH - 1;

    logic [`BYPASS_DEPTH-1:0] validQ;
    RegAddr addrQ [`BYPASS_DEPTH];
    Word valueQ [`BYPASS_DEPTH];

    // Valid bits carry the control state
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            validQ <= '0;
        end else if (!stall) begin
            // x0 writes load as invalid so x0 never enters the bypass
            validQ <= {validQ[LastStage-1:0], writeEnable && (writeAddr != '0)};
        end
    end

    // Payload shifts alongside the valid bits
    always_ff @(posedge clk) begin
        if (!stall) begin
            addrQ[0] <= writeAddr;
            valueQ[0] <= writeValue;
            for (int i = 1; i < `BYPASS_DEPTH; i++) begin
                addrQ[i] <= addrQ[i-1];
                valueQ[i] <= valueQ[i-1];
            end
        end
    end

    assign stageValid = validQ;
    assign stageAddr = addrQ;
    assign stageValue = valueQ;

    // Oldest stage drains into the register file on the next free edge
    assign retireEnable = validQ[LastStage] && !stall && !flush;
    assign retireAddr = addrQ[LastStage];
    assign retireValue = valueQ[LastStage];

endmodule

//--- hdl/BypassLookup.sv
// Single read port CAM search of the bypass stages, newest match wins
`timescale 1ns/1ps

`include "bypass_defs.svh"

module BypassLookup (
    input  BypassPkg::RegAddr          readAddr,
    input  logic [`BYPASS_DEPTH-1:0]   stageValid,
    input  BypassPkg::RegAddr          stageAddr [`BYPASS_DEPTH],
    input  BypassPkg::Word             stageValue [`BYPASS_DEPTH],
    output logic                       hit,
    output BypassPkg::Word             value
);
    import BypassPkg::*;

    logic [`BYPASS_DEPTH-1:0] match;
    StageIndex matchIndex;

    // Address compare against every valid stage
    always_comb begin
        for (int i = 0; i < `BYPASS_DEPTH; i++) begin
            match[i] = stageValid[i] && (stageAddr[i] == readAddr);
        end
    end

    // Priority encode, scanning oldest to newest so the lowest index sticks
    always_comb begin
        matchIndex = '0;
        for (int i = `BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (match[i]) begin
                matchIndex = StageIndex'(i);
            end
        end
    end

    assign hit = |match;

    // Zero on a miss so the register file value is taken cleanly
    always_comb begin
        if (hit) begin
            value = stageValue[matchIndex];
        end else begin
            value = '0;
        end
    end

endmodule

//--- hdl/OperandRegFile.sv
// Architectural register file fed by retirement, with bypass or stored operand select
`timescale 1ns/1ps

`include "bypass_defs.svh"

module OperandRegFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       retireEnable,
    input  BypassPkg::RegAddr          retireAddr,
    input  BypassPkg::Word             retireValue,
    input  BypassPkg::RegAddr          readAddr [`READ_PORTS],
    input  logic [`READ_PORTS-1:0]     lookupHit,
    input  BypassPkg::Word             lookupValue [`READ_PORTS],
    output BypassPkg::Word             readValue [`READ_PORTS]
);
    import BypassPkg::*;

    localparam int RegCount = 1 << `REG_ADDR_WIDTH;

    // x0 has no storage, only registers 1 and up
    Word regs [1:RegCount-1];

    Word storedValue [`READ_PORTS];

    // Retiring write
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 1; r < RegCount; r++) begin
                regs[r] <= '0;
            end
        end else if (retireEnable && (retireAddr != '0)) begin
            regs[retireAddr] <= retireValue;
        end
    end

    // Stored operand per port
    always_comb begin
        for (int p = 0; p < `READ_PORTS; p++) begin
            if (readAddr[p] == '0) begin
                storedValue[p] = '0;
            end else begin
                storedValue[p] = regs[readAddr[p]];
            end
        end
    end

    // In-flight result takes precedence over the architectural copy
    always_comb begin
        for (int p = 0; p < `READ_PORTS; p++) begin
            if (lookupHit[p]) begin
                readValue[p] = lookupValue[p];
            end else begin
                readValue[p] = storedValue[p];
            end
        end
    end

endmodule

//--- hdl/OperandForward.sv
// Operand forwarding top joining the bypass pipeline, lookup ports and register file
`timescale 1ns/1ps

`include "bypass_defs.svh"

module OperandForward (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       stall,
    input  logic                       writeEnable,
    input  BypassPkg::RegAddr          writeAddr,
    input  BypassPkg::Word             writeValue,
    input  BypassPkg::RegAddr          readAddr [`READ_PORTS],
    output BypassPkg::Word             readValue [`READ_PORTS],
    output logic [`READ_PORTS-1:0]     hit
);
    import BypassPkg::*;

    logic [`BYPASS_DEPTH-1:0] stageValid;
    RegAddr stageAddr [`BYPASS_DEPTH];
    Word stageValue [`BYPASS_DEPTH];

    logic retireEnable;
    RegAddr retireAddr;
    Word retireValue;

    logic [`READ_PORTS-1:0] lookupHit;
    Word lookupValue [`READ_PORTS];

    BypassPipeline i_pipeline (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .stall        (stall),
        .writeEnable  (writeEnable),
        .writeAddr    (writeAddr),
        .writeValue   (writeValue),
        .stageValid   (stageValid),
        .stageAddr    (stageAddr),
        .stageValue   (stageValue),
        .retireEnable (retireEnable),
        .retireAddr   (retireAddr),
        .retireValue  (retireValue)
    );

    // One CAM search per read port
    for (genvar i = 0; i < `READ_PORTS; i++) begin : gLookup
        BypassLookup i_lookup (
            .readAddr   (readAddr[i]),
            .stageValid (stageValid),
            .stageAddr  (stageAddr),
            .stageValue (stageValue),
            .hit        (lookupHit[i]),
            .value      (lookupValue[i])
        );
    end

    OperandRegFile i_regFile (
        .clk          (clk),
        .rst          (rst),
        .retireEnable (retireEnable),
        .retireAddr   (retireAddr),
        .retireValue  (retireValue),
        .readAddr     (readAddr),
        .lookupHit    (lookupHit),
        .lookupValue  (lookupValue),
        .readValue    (readValue)
    );

    assign hit = lookupHit;

endmodule

//--- bench/OperandForward_assert.sv
// Bound checks on reset, stall hold, flush clear and the zero register
`timescale 1ns/1ps

`include "bypass_defs.svh"

module OperandForward_assert (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       stall,
    input  logic [`BYPASS_DEPTH-1:0]   stageValid,
    input  BypassPkg::RegAddr          stageAddr [`BYPASS_DEPTH],
    input  BypassPkg::Word             stageValue [`BYPASS_DEPTH],
    input  logic                       retireEnable,
    input  BypassPkg::RegAddr          readAddr [`READ_PORTS],
    input  BypassPkg::Word             readValue [`READ_PORTS],
    input  logic [`READ_PORTS-1:0]     hit
);
    import BypassPkg::*;

    // Count of failed checks
    int assertFails = 0;

    logic [`BYPASS_DEPTH*`REG_ADDR_WIDTH-1:0] addrFlat;
    logic [`BYPASS_DEPTH*`WORD_WIDTH-1:0] valueFlat;

    // Packed copies of the stage payload for $past
    always_comb begin
        for (int i = 0; i < `BYPASS_DEPTH; i++) begin
            addrFlat[i*`REG_ADDR_WIDTH +: `REG_ADDR_WIDTH] = stageAddr[i];
            valueFlat[i*`WORD_WIDTH +: `WORD_WIDTH] = stageValue[i];
        end
    end

    resetClears: assert property (@(posedge clk) rst |=> (hit == '0) && !retireEnable)
        else begin
            $error("hit or retireEnable high after reset");
            assertFails++;
        end

    stallHolds: assert property (@(posedge clk) (stall && !rst && !flush) |=>
            (stageValid == $past(stageValid)) && (addrFlat == $past(addrFlat)) &&
            (valueFlat == $past(valueFlat)))
        else begin
            $error("bypass stages changed across a stalled edge");
            assertFails++;
        end

    flushClears: assert property (@(posedge clk) flush |=> (stageValid == '0))
        else begin
            $error("stage still valid after flush");
            assertFails++;
        end

    // x0 reads as zero and never hits, on every port
    for (genvar p = 0; p < `READ_PORTS; p++) begin : gZeroReg
        zeroRead: assert property (@(posedge clk) disable iff (rst)
                (readAddr[p] == '0) |-> (readValue[p] == '0) && !hit[p])
            else begin
                $error("read of x0 gave nonzero value or hit");
                assertFails++;
            end
    end

endmodule

//--- bench/OperandForward_tb.sv
// Operand forwarding testbench with reference model, directed and random tests
`timescale 1ns/1ps

`include "bypass_defs.svh"

module OperandForward_tb;
    import BypassPkg::*;

    localparam int ClkPeriod = 8;
    localparam int RegCount = 1 << `REG_ADDR_WIDTH;
    localparam int RandomCycles = 300;
    // Upper bound on reset plus all directed tests, in cycles
    localparam int DirectedCycles = 80;
    localparam int MarginCycles = 100;
    localparam int TotalCycles = DirectedCycles + RandomCycles + MarginCycles;

    logic clk = 1'b0;
    logic rst;
    logic flush;
    logic stall;
    logic writeEnable;
    RegAddr writeAddr;
    Word writeValue;
    RegAddr readAddr [`READ_PORTS];
    Word readValue [`READ_PORTS];
    logic [`READ_PORTS-1:0] hit;

    // Shadow register file and bypass pipeline
    Word modelRegs [RegCount];
    logic modelValid [`BYPASS_DEPTH];
    RegAddr modelAddr [`BYPASS_DEPTH];
    Word modelValue [`BYPASS_DEPTH];

    string currentTest;
    int testErrors;
    int passCount;
    int failCount;
    logic checkEnable;
    integer seed = 32'h09cc3f80;

    OperandForward i_dut (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .stall       (stall),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeValue  (writeValue),
        .readAddr    (readAddr),
        .readValue   (readValue),
        .hit         (hit)
    );

    bind OperandForward OperandForward_assert i_assert (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .stall        (stall),
        .stageValid   (stageValid),
        .stageAddr    (stageAddr),
        .stageValue   (stageValue),
        .retireEnable (retireEnable),
        .readAddr     (readAddr),
        .readValue    (readValue),
        .hit          (hit)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // Reference model, follows the write, retire, stall and flush rules
    always @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < RegCount; r++) begin
                modelRegs[r] <= '0;
            end
            for (int s = 0; s < `BYPASS_DEPTH; s++) begin
                modelValid[s] <= 1'b0;
            end
        end else if (flush) begin
            for (int s = 0; s < `BYPASS_DEPTH; s++) begin
                modelValid[s] <= 1'b0;
            end
        end else if (!stall) begin
            if (modelValid[`BYPASS_DEPTH-1]) begin
                modelRegs[modelAddr[`BYPASS_DEPTH-1]] <= modelValue[`BYPASS_DEPTH-1];
            end
            for (int s = `BYPASS_DEPTH - 1; s > 0; s--) begin
                modelValid[s] <= modelValid[s-1];
                modelAddr[s] <= modelAddr[s-1];
                modelValue[s] <= modelValue[s-1];
            end
            modelValid[0] <= writeEnable && (writeAddr != '0);
            modelAddr[0] <= writeAddr;
            modelValue[0] <= writeValue;
        end
    end

    function automatic logic expectHit(RegAddr addr);
        logic found;
        found = 1'b0;
        for (int s = 0; s < `BYPASS_DEPTH; s++) begin
            if (modelValid[s] && (modelAddr[s] == addr)) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Newest in-flight copy wins, else the shadow register
    function automatic Word expectValue(RegAddr addr);
        Word result;
        result = modelRegs[addr];
        for (int s = `BYPASS_DEPTH - 1; s >= 0; s--) begin
            if (modelValid[s] && (modelAddr[s] == addr)) begin
                result = modelValue[s];
            end
        end
        return result;
    endfunction

    task automatic checkPort(int port, Word expValue, logic expHit);
        assert (hit[port] === expHit) else begin
            $display("[ERROR] %s: port %0d hit expected %0b actual %0b",
                currentTest, port, expHit, hit[port]);
            testErrors++;
        end
        assert (readValue[port] === expValue) else begin
            $display("[ERROR] %s: port %0d readValue expected %h actual %h",
                currentTest, port, expValue, readValue[port]);
            testErrors++;
        end
    endtask

    // Every port against the model on each falling edge
    always @(negedge clk) begin
        if (checkEnable) begin
            for (int p = 0; p < `READ_PORTS; p++) begin
                checkPort(p, expectValue(readAddr[p]), expectHit(readAddr[p]));
            end
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic writeReg(RegAddr addr, Word value);
        writeEnable = 1'b1;
        writeAddr = addr;
        writeValue = value;
        nextCycle();
        writeEnable = 1'b0;
    endtask

    task automatic setReads(RegAddr addr);
        for (int p = 0; p < `READ_PORTS; p++) begin
            readAddr[p] = addr;
        end
    endtask

    // Directed check on all ports, then one more edge
    task automatic checkCycle(Word expValue, logic expHit);
        @(negedge clk);
        for (int p = 0; p < `READ_PORTS; p++) begin
            checkPort(p, expValue, expHit);
        end
        nextCycle();
    endtask

    task automatic startTest(string name);
        currentTest = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            $display("PASS %s", currentTest);
            passCount++;
        end else begin
            $display("FAIL %s with %0d mismatches", currentTest, testErrors);
            failCount++;
        end
    endtask

    initial begin
        #(TotalCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, tests did not finish", TotalCycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        writeEnable = 1'b0;
        writeAddr = '0;
        writeValue = '0;
        setReads('0);
        checkEnable = 1'b0;
        passCount = 0;
        failCount = 0;
        repeat (2) nextCycle();
        rst = 1'b0;
        checkEnable = 1'b1;

        startTest("forwarding");
        setReads(5'd5);
        writeReg(5'd5, 32'h1234_5678);
        checkCycle(32'h1234_5678, 1'b1);
        finishTest();

        startTest("newest wins");
        setReads(5'd7);
        writeReg(5'd7, 32'haaaa_0001);
        writeReg(5'd7, 32'hbbbb_0002);
        checkCycle(32'hbbbb_0002, 1'b1);
        finishTest();

        startTest("retirement");
        setReads(5'd9);
        writeReg(5'd9, 32'hc0de_0009);
        repeat (`BYPASS_DEPTH - 1) nextCycle();
        checkCycle(32'hc0de_0009, 1'b1);
        checkCycle(32'hc0de_0009, 1'b0);
        finishTest();

        startTest("zero register");
        setReads('0);
        for (int i = 0; i < `BYPASS_DEPTH + 1; i++) begin
            writeReg('0, 32'hdead_0000 + i);
            checkCycle('0, 1'b0);
        end
        finishTest();

        startTest("stall");
        setReads(5'd11);
        writeReg(5'd11, 32'h5a11_000b);
        nextCycle();
        // A write offered during the stall must not be taken
        stall = 1'b1;
        writeEnable = 1'b1;
        writeAddr = 5'd11;
        writeValue = 32'h0bad_0bad;
        repeat (4) checkCycle(32'h5a11_000b, 1'b1);
        stall = 1'b0;
        writeEnable = 1'b0;
        checkCycle(32'h5a11_000b, 1'b1);
        checkCycle(32'h5a11_000b, 1'b1);
        checkCycle(32'h5a11_000b, 1'b0);
        finishTest();

        startTest("flush");
        setReads(5'd13);
        writeReg(5'd13, 32'hf1f1_000d);
        repeat (`BYPASS_DEPTH) nextCycle();
        checkCycle(32'hf1f1_000d, 1'b0);
        writeReg(5'd13, 32'hf2f2_000d);
        checkCycle(32'hf2f2_000d, 1'b1);
        flush = 1'b1;
        checkCycle(32'hf2f2_000d, 1'b1);
        flush = 1'b0;
        repeat (`BYPASS_DEPTH + 1) checkCycle(32'hf1f1_000d, 1'b0);
        finishTest();

        startTest("random mix");
        for (int c = 0; c < RandomCycles; c++) begin
            writeEnable = 1'($random(seed));
            // Small address range so reads hit in-flight entries often
            writeAddr = RegAddr'($random(seed) & 7);
            writeValue = Word'($random(seed));
            stall = (($random(seed) & 7) == 0);
            flush = (($random(seed) & 15) == 0);
            for (int p = 0; p < `READ_PORTS; p++) begin
                readAddr[p] = RegAddr'($random(seed) & 7);
            end
            nextCycle();
        end
        writeEnable = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        finishTest();

        $display("Summary: %0d tests passed, %0d tests failed, %0d bound assertion failures",
            passCount, failCount, i_dut.i_assert.assertFails);
        if (failCount == 0 && i_dut.i_assert.assertFails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- OperandForward.f
+incdir+hdl
hdl/BypassPkg.sv
hdl/BypassPipeline.sv
hdl/BypassLookup.sv
hdl/OperandRegFile.sv
hdl/OperandForward.sv
bench/OperandForward_assert.sv
bench/OperandForward_tb.sv

//--- Bender.yml
package:
  name: operand_forward

export_include_dirs:
  - hdl

sources:
  # Synthesizable design, package first
  - include_dirs:
      - hdl
    files:
      - hdl/BypassPkg.sv
      - hdl/BypassPipeline.sv
      - hdl/BypassLookup.sv
      - hdl/OperandRegFile.sv
      - hdl/OperandForward.sv
  # Testbench and bound assertions
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/OperandForward_assert.sv
      - bench/OperandForward_tb.sv
